/* filelist.f */
source/rename_pkg.sv
source/register_map.sv
source/reorder_buffer.sv
source/rename_csr.sv
source/rename_top.sv
bench/rename_props.sv
bench/rename_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the rename core simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module rename_tb &&
./obj_dir/Vrename_tb | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation run succeeded" ||
{ echo "Simulation run failed"; exit 1; }

/* bench/rename_tb.sv */
// Rename core testbench
`timescale 1ns/100ps

module rename_tb
    import rename_pkg::*;
();

    localparam int timeout_cycles_c = 200;

    logic          clk;
    logic          n_rst;
    dispatch_req_t dispatch;
    logic          dispatch_ready;
    lookup_rsp_t   lookup;
    complete_t     complete;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    csr_addr_t     wb_adr;
    data_t         wb_dat_w;
    data_t         wb_dat_r;
    logic          wb_ack;

    // Reference model of the register map as seen at lookup
    data_t model_data  [reg_count_c];
    tag_t  model_tag   [reg_count_c];
    logic  model_rdy   [reg_count_c];
    logic  model_known [reg_count_c];
    tag_t  next_tag;
    int    retired;

    // Instructions still in the buffer, oldest first
    reg_idx_t inflight_rd   [$];
    tag_t     inflight_tag  [$];
    data_t    inflight_data [$];

    int     checks;
    int     errors;
    int     timeouts;
    integer seed;
    data_t  rd_val;

    rename_top rename_top_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .lookup         (lookup),
        .complete       (complete),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t while waiting for %s", $time, what);
    endtask

    // One Wishbone classic cycle, held until the acknowledging edge has passed
    task automatic wb_access(input logic we, input csr_addr_t adr, input data_t wdata,
                             output data_t rdata);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < timeout_cycles_c);
        if (!wb_ack) begin
            report_timeout("wb_ack");
        end
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // Both sources look up the same register so both ports are covered
    task automatic lookup_check(input reg_idx_t r);
        @(negedge clk);
        dispatch.valid = 1'b0;
        dispatch.rsrc0 = r;
        dispatch.rsrc1 = r;
        #2;
        check_value($sformatf("lookup.src0.rdy r%0d", r), data_t'(lookup.src0.rdy),
                    data_t'(model_rdy[r]));
        check_value($sformatf("lookup.src1.rdy r%0d", r), data_t'(lookup.src1.rdy),
                    data_t'(model_rdy[r]));
        if (model_known[r]) begin
            check_value($sformatf("lookup.src0.data r%0d", r), lookup.src0.data, model_data[r]);
            check_value($sformatf("lookup.src1.data r%0d", r), lookup.src1.data, model_data[r]);
        end
        // The tag only means something while the register waits for a producer
        if (!model_rdy[r]) begin
            check_value($sformatf("lookup.src0.tag r%0d", r), data_t'(lookup.src0.tag),
                        data_t'(model_tag[r]));
            check_value($sformatf("lookup.src1.tag r%0d", r), data_t'(lookup.src1.tag),
                        data_t'(model_tag[r]));
        end
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < reg_count_c; r++) begin
            lookup_check(reg_idx_t'(r));
        end
    endtask

    task automatic dispatch_instr(input reg_idx_t rd);
        int n;
        @(negedge clk);
        dispatch.valid = 1'b1;
        dispatch.rdest = rd;
        dispatch.rsrc0 = reg_idx_t'($random(seed));
        dispatch.rsrc1 = reg_idx_t'($random(seed));
        n = 0;
        while (!dispatch_ready && n < timeout_cycles_c) begin
            @(negedge clk);
            n++;
        end
        if (!dispatch_ready) begin
            report_timeout("dispatch_ready");
        end else begin
            check_value("lookup.alloc_tag", data_t'(lookup.alloc_tag), data_t'(next_tag));
            inflight_rd.push_back(rd);
            inflight_tag.push_back(next_tag);
            inflight_data.push_back(data_t'($random(seed)));
            if (rd != '0) begin
                model_tag[rd] = next_tag;
                model_rdy[rd] = 1'b0;
            end
            next_tag++;
        end
        @(negedge clk);
        dispatch.valid = 1'b0;
    endtask

    task automatic complete_entry(input int i);
        @(negedge clk);
        complete.valid = 1'b1;
        complete.tag   = inflight_tag[i];
        complete.data  = inflight_data[i];
        @(negedge clk);
        complete.valid = 1'b0;
    endtask

    // Results arrive in a random order, retirement must still be in order
    task automatic complete_shuffled();
        int order [$];
        int j;
        int tmp;
        for (int i = 0; i < inflight_tag.size(); i++) begin
            order.push_back(i);
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            complete_entry(order[k]);
        end
    endtask

    // Retirement rule, data always lands but rdy needs a matching tag
    task automatic retire_oldest();
        reg_idx_t rd;
        tag_t     t;
        data_t    d;
        rd = inflight_rd.pop_front();
        t  = inflight_tag.pop_front();
        d  = inflight_data.pop_front();
        retired++;
        if (rd != '0) begin
            model_data[rd]  = d;
            model_known[rd] = 1'b1;
            if (model_tag[rd] == t) begin
                model_rdy[rd] = 1'b1;
            end
        end
    endtask

    // Waits for occupancy to fall to target, then retires the model to match
    task automatic drain_to(input int target);
        data_t occ;
        int n;
        n = 0;
        wb_access(1'b0, occupancy_addr_c, '0, occ);
        while (occ != data_t'(target) && n < timeout_cycles_c) begin
            wb_access(1'b0, occupancy_addr_c, '0, occ);
            n++;
        end
        if (occ != data_t'(target)) begin
            report_timeout("occupancy to fall");
        end
        while (inflight_tag.size() > target) begin
            retire_oldest();
        end
    endtask

    initial begin
        seed     = 32'hf31b;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        retired  = 0;
        next_tag = '0;
        for (int r = 0; r < reg_count_c; r++) begin
            model_data[r]  = '0;
            model_tag[r]   = '0;
            model_rdy[r]   = 1'b1;
            model_known[r] = (r == 0);
        end
        n_rst    = 1'b0;
        dispatch = '0;
        complete = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // Everything comes up ready and empty
        check_value("dispatch_ready", data_t'(dispatch_ready), 32'd1);
        check_all_regs();
        wb_access(1'b0, occupancy_addr_c, '0, rd_val);
        check_value("occupancy", rd_val, 32'd0);
        wb_access(1'b0, retired_addr_c, '0, rd_val);
        check_value("retired count", rd_val, 32'd0);

        // Tags are handed out in order and show up at lookup
        for (int i = 1; i <= 8; i++) begin
            dispatch_instr(reg_idx_t'(i));
        end
        check_all_regs();
        complete_shuffled();
        drain_to(0);
        check_all_regs();
        wb_access(1'b0, retired_addr_c, '0, rd_val);
        check_value("retired count", rd_val, data_t'(retired));

        // Older producer retires first and must not set rdy
        dispatch_instr(reg_idx_t'(5));
        dispatch_instr(reg_idx_t'(5));
        complete_entry(0);
        drain_to(1);
        lookup_check(reg_idx_t'(5));
        complete_entry(0);
        drain_to(0);
        lookup_check(reg_idx_t'(5));

        // Hold retirement and fill the buffer, the tail wraps on the way
        wb_access(1'b1, ctrl_addr_c, 32'h1, rd_val);
        for (int i = 1; i <= rob_depth_c; i++) begin
            dispatch_instr(reg_idx_t'(i));
        end
        check_value("dispatch_ready", data_t'(dispatch_ready), 32'd0);
        // A request offered to the full buffer must not be taken
        @(negedge clk);
        dispatch.valid = 1'b1;
        dispatch.rdest = reg_idx_t'(1);
        @(negedge clk);
        dispatch.valid = 1'b0;
        wb_access(1'b0, occupancy_addr_c, '0, rd_val);
        check_value("occupancy", rd_val, data_t'(rob_depth_c));
        complete_shuffled();
        wb_access(1'b1, ctrl_addr_c, 32'h0, rd_val);
        drain_to(0);
        check_all_regs();

        // A result for r0 is thrown away
        dispatch_instr(reg_idx_t'(0));
        complete_entry(0);
        drain_to(0);
        lookup_check(reg_idx_t'(0));

        // Flush with work in flight keeps the retired data
        dispatch_instr(reg_idx_t'(2));
        dispatch_instr(reg_idx_t'(3));
        // Both lookup ports watch registers that still wait on a producer
        @(negedge clk);
        dispatch.rsrc0 = reg_idx_t'(2);
        dispatch.rsrc1 = reg_idx_t'(3);
        wb_access(1'b1, ctrl_addr_c, 32'h2, rd_val);
        inflight_rd.delete();
        inflight_tag.delete();
        inflight_data.delete();
        for (int r = 0; r < reg_count_c; r++) begin
            model_rdy[r] = 1'b1;
        end
        next_tag = '0;
        wb_access(1'b0, occupancy_addr_c, '0, rd_val);
        check_value("occupancy", rd_val, 32'd0);
        wb_access(1'b0, ctrl_addr_c, '0, rd_val);
        check_value("control", rd_val, 32'd0);
        check_all_regs();
        wb_access(1'b0, retired_addr_c, '0, rd_val);
        check_value("retired count", rd_val, data_t'(retired));
        dispatch_instr(reg_idx_t'(7));

        $display("Closing: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* bench/rename_props.sv */
// Rename core assertions
`timescale 1ns/100ps

module rename_props
    import rename_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input logic          clk,
    input logic          n_rst,
    input dispatch_req_t dispatch,
    input logic          dispatch_ready,
    input lookup_rsp_t   lookup,
    input count_t        occupancy,
    input logic          flush,
    input logic          wb_cyc,
    input logic          wb_stb,
    input logic          wb_ack
);

    // Register r0 is hardwired to zero and always ready on both ports
    r0_src0_a: assert property (@(posedge clk) disable iff (!n_rst)
        dispatch.rsrc0 == '0 |-> lookup.src0.data == '0 && lookup.src0.rdy)
        else $error("r0 lookup on source 0 is not zero and ready");

    r0_src1_a: assert property (@(posedge clk) disable iff (!n_rst)
        dispatch.rsrc1 == '0 |-> lookup.src1.data == '0 && lookup.src1.rdy)
        else $error("r0 lookup on source 1 is not zero and ready");

    // A full buffer must push back on dispatch
    full_a: assert property (@(posedge clk) disable iff (!n_rst)
        occupancy == count_t'(DEPTH) |-> !dispatch_ready)
        else $error("dispatch accepted while the buffer is full");

    // An acknowledge is only ever an answer to a strobe
    ack_a: assert property (@(posedge clk) disable iff (!n_rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding strobe");

    // After a flush nothing is waiting on a producer
    flush_a: assert property (@(posedge clk) disable iff (!n_rst)
        flush |=> lookup.src0.rdy && lookup.src1.rdy)
        else $error("source not ready after a flush");

endmodule

bind rename_top rename_props #(
    .DEPTH(DEPTH)
) rename_props_inst (
    .clk            (clk),
    .n_rst          (n_rst),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .lookup         (lookup),
    .occupancy      (occupancy),
    .flush          (flush),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack)
);

/* source/rename_top.sv */
// Register rename core
`timescale 1ns/100ps

module rename_top
    import rename_pkg::*;
#(
    parameter int DEPTH = rob_depth_c,
    parameter int REGS  = reg_count_c
) (
    input  logic          clk,
    input  logic          n_rst,

    // Dispatch stage
    input  dispatch_req_t dispatch,
    output logic          dispatch_ready,
    output lookup_rsp_t   lookup,

    // Execution results
    input  complete_t     complete,

    // Wishbone configuration port
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  csr_addr_t     wb_adr,
    input  data_t         wb_dat_w,
    output data_t         wb_dat_r,
    output logic          wb_ack
);

    tag_write_t tag_wr;
    writeback_t retire_wb;
    count_t     occupancy;
    logic       retire_pulse;
    logic       retire_hold;
    logic       flush;
    src_rsp_t   src0;
    src_rsp_t   src1;
    tag_t       alloc_tag;

    // Operand state comes from the map, the new tag from the buffer
    assign lookup = '{src0: src0, src1: src1, alloc_tag: alloc_tag};

    register_map #(
        .REGS(REGS)
    ) register_map_inst (
        .clk    (clk),
        .n_rst  (n_rst),
        .flush  (flush),
        .tag_wr (tag_wr),
        .wb     (retire_wb),
        .rsrc0  (dispatch.rsrc0),
        .rsrc1  (dispatch.rsrc1),
        .src0   (src0),
        .src1   (src1)
    );

    reorder_buffer #(
        .DEPTH(DEPTH)
    ) reorder_buffer_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .alloc_tag      (alloc_tag),
        .complete       (complete),
        .retire_hold    (retire_hold),
        .flush          (flush),
        .tag_wr         (tag_wr),
        .wb             (retire_wb),
        .occupancy      (occupancy),
        .retire_pulse   (retire_pulse)
    );

    rename_csr rename_csr_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .occupancy    (occupancy),
        .retire_pulse (retire_pulse),
        .retire_hold  (retire_hold),
        .flush        (flush)
    );

endmodule

/* source/rename_csr.sv */
// Rename configuration registers
`timescale 1ns/100ps

module rename_csr
    import rename_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    // Wishbone classic slave
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  csr_addr_t wb_adr,
    input  data_t     wb_dat_w,
    output data_t     wb_dat_r,
    output logic      wb_ack,

    // Status from the reorder buffer
    input  count_t    occupancy,
    input  logic      retire_pulse,

    // Control to the core
    output logic      retire_hold,
    output logic      flush
);

    logic  ack_q;
    logic  hold_q;
    logic  flush_q;
    data_t retired_q;
    logic  wr_stb;

    // A write lands on the edge that ends the acknowledge cycle
    assign wr_stb = wb_cyc && wb_stb && wb_we && ack_q;

    // Single-cycle acknowledge, one cycle after the request appears
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc && wb_stb && !ack_q;
        end
    end

    // Control register, bit 1 only ever produces a one-cycle flush
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            hold_q  <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            flush_q <= wr_stb && (wb_adr == ctrl_addr_c) && wb_dat_w[1];
            if (wr_stb && (wb_adr == ctrl_addr_c)) begin
                hold_q <= wb_dat_w[0];
            end
        end
    end

    // Retired instruction count, any write to it clears it
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            retired_q <= '0;
        end else if (wr_stb && (wb_adr == retired_addr_c)) begin
            retired_q <= '0;
        end else if (retire_pulse) begin
            retired_q <= retired_q + data_t'(1);
        end
    end

    // Read mux, the flush bit always reads back as zero
    always_comb begin
        case (wb_adr)
            ctrl_addr_c:      wb_dat_r = data_t'(hold_q);
            occupancy_addr_c: wb_dat_r = data_t'(occupancy);
            retired_addr_c:   wb_dat_r = retired_q;
            default:          wb_dat_r = '0;
        endcase
    end

    assign wb_ack      = ack_q;
    assign retire_hold = hold_q;
    assign flush       = flush_q;

endmodule

/* source/reorder_buffer.sv */
// In-order retirement buffer
`timescale 1ns/100ps

module reorder_buffer
    import rename_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic          clk,
    input  logic          n_rst,

    // Dispatch side, the allocated tag is the current tail
    input  dispatch_req_t dispatch,
    output logic          dispatch_ready,
    output tag_t          alloc_tag,

    // Results from the execution units
    input  complete_t     complete,

    // Control from the configuration block
    input  logic          retire_hold,
    input  logic          flush,

    // Updates to the register map
    output tag_write_t    tag_wr,
    output writeback_t    wb,

    // Status for the configuration block
    output count_t        occupancy,
    output logic          retire_pulse
);

    // Pointers wrap at DEPTH, which also fits a tag exactly
    tag_t   head_q;
    tag_t   tail_q;
    count_t count_q;

    // Per-entry control flags
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] done_q;

    // Per-entry payload
    reg_idx_t rdest_q [DEPTH];
    data_t    data_q  [DEPTH];

    logic do_dispatch;
    logic do_complete;
    logic do_retire;

    function automatic tag_t next_ptr(input tag_t ptr);
        if (ptr == tag_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + tag_t'(1);
    endfunction

    // Back-pressure while full or while the flush pulse is high
    assign dispatch_ready = (count_q != count_t'(DEPTH)) && !flush;
    assign do_dispatch    = dispatch.valid && dispatch_ready;

    // Results for entries that are not allocated are dropped
    assign do_complete = complete.valid && valid_q[complete.tag] && !flush;

    // Only the oldest entry may leave, and only once it has its result
    assign do_retire = valid_q[head_q] && done_q[head_q] && !retire_hold && !flush;

    // Control state
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush) begin
            // Everything in flight is discarded
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (do_dispatch) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= next_ptr(tail_q);
            end
            if (do_complete) begin
                done_q[complete.tag] <= 1'b1;
            end
            // Retire comes last so a late duplicate result cannot revive the entry
            if (do_retire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            // Dispatch and retire together leave the count unchanged
            case ({do_dispatch, do_retire})
                2'b10:   count_q <= count_q + count_t'(1);
                2'b01:   count_q <= count_q - count_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (do_dispatch) begin
            rdest_q[tail_q] <= dispatch.rdest;
        end
        if (do_complete) begin
            data_q[complete.tag] <= complete.data;
        end
    end

    assign alloc_tag = tail_q;

    // Tag update for the destination of the accepted instruction
    assign tag_wr.wr_en = do_dispatch;
    assign tag_wr.rdest = dispatch.rdest;
    assign tag_wr.tag   = tail_q;

    // Head entry goes back to the map on retirement
    assign wb.wr_en = do_retire;
    assign wb.rdest = rdest_q[head_q];
    assign wb.tag   = head_q;
    assign wb.data  = data_q[head_q];

    assign occupancy    = count_q;
    assign retire_pulse = do_retire;

endmodule

/* source/register_map.sv */
// Renamed register map
`timescale 1ns/100ps

module register_map
    import rename_pkg::*;
#(
    parameter int REGS = 32
) (
    input  logic       clk,
    input  logic       n_rst,

    // Pulses for one cycle to drop every outstanding tag
    input  logic       flush,

    // New producer tag for a destination register
    input  tag_write_t tag_wr,

    // Retired result for a destination register
    input  writeback_t wb,

    // Source register numbers and their lookup results
    input  reg_idx_t   rsrc0,
    input  reg_idx_t   rsrc1,
    output src_rsp_t   src0,
    output src_rsp_t   src1
);

    // Data and tag need no reset and can map onto RAM
    // Entry 0 of both is never written since r0 is hardwired
    data_t data_q [REGS];
    tag_t  tag_q  [REGS];

    // Ready bits are real flops because they must come up set
    logic [REGS-1:0] rdy_q;

    // One-hot selects, bit 0 always stays low so r0 is never touched
    logic [REGS-1:0] tag_wr_sel;
    logic [REGS-1:0] wb_sel;

    always_comb begin
        tag_wr_sel = '0;
        wb_sel     = '0;
        for (int i = 1; i < REGS; i++) begin
            tag_wr_sel[i] = tag_wr.wr_en && (tag_wr.rdest == reg_idx_t'(i));
            wb_sel[i]     = wb.wr_en && (wb.rdest == reg_idx_t'(i));
        end
    end

    // Tags follow dispatch and data follows retirement
    always_ff @(posedge clk) begin
        for (int i = 1; i < REGS; i++) begin
            if (tag_wr_sel[i]) begin
                tag_q[i] <= tag_wr.tag;
            end
            // Retired data is always architecturally newest, even if a
            // younger producer for the same register is still in flight
            if (wb_sel[i]) begin
                data_q[i] <= wb.data;
            end
        end
    end

    // Ready priority is flush, then a new tag, then a matching write-back
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rdy_q <= '1;
        end else if (flush) begin
            // The map already holds the last retired values, so dropping
            // the tags is enough to recover
            rdy_q <= '1;
        end else begin
            for (int i = 0; i < REGS; i++) begin
                if (tag_wr_sel[i]) begin
                    rdy_q[i] <= 1'b0;
                end else if (wb_sel[i] && (wb.tag == tag_q[i])) begin
                    // A stale tag means a younger instruction still owns the register
                    rdy_q[i] <= 1'b1;
                end
            end
        end
    end

    // Lookup reads the state from before the current edge
    function automatic src_rsp_t read_src(input reg_idx_t idx);
        src_rsp_t rsp;
        if (idx == '0) begin
            rsp.data = '0;
            rsp.tag  = '0;
            rsp.rdy  = 1'b1;
        end else begin
            rsp.data = data_q[idx];
            rsp.tag  = tag_q[idx];
            rsp.rdy  = rdy_q[idx];
        end
        return rsp;
    endfunction

    always_comb begin
        src0 = read_src(rsrc0);
        src1 = read_src(rsrc1);
    end

endmodule

/* source/rename_pkg.sv */
// Rename core shared definitions
package rename_pkg;

    // Architectural register file shape
    localparam int data_width_c = 32;
    localparam int reg_count_c  = 32;

    // Reorder buffer entries, which is also the number of rename tags
    localparam int rob_depth_c = 16;

    typedef logic [data_width_c-1:0]        data_t;
    typedef logic [$clog2(reg_count_c)-1:0] reg_idx_t;
    typedef logic [$clog2(rob_depth_c)-1:0] tag_t;
    // One bit wider than a tag so a full buffer can be counted
    typedef logic [$clog2(rob_depth_c):0]   count_t;
    typedef logic [1:0]                     csr_addr_t;

    // Configuration register word addresses
    localparam csr_addr_t ctrl_addr_c      = 2'd0;
    localparam csr_addr_t occupancy_addr_c = 2'd1;
    localparam csr_addr_t retired_addr_c   = 2'd2;

    // One instruction from the dispatch stage
    typedef struct packed {
        logic     valid;
        reg_idx_t rdest;
        reg_idx_t rsrc0;
        reg_idx_t rsrc1;
    } dispatch_req_t;

    // Operand state for one source register
    typedef struct packed {
        data_t data;
        tag_t  tag;
        logic  rdy;
    } src_rsp_t;

    // Full answer returned to the dispatch stage
    typedef struct packed {
        src_rsp_t src0;
        src_rsp_t src1;
        tag_t     alloc_tag;
    } lookup_rsp_t;

    // Result reported by an execution unit
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } complete_t;

    // Retirement write into the register map
    typedef struct packed {
        logic     wr_en;
        reg_idx_t rdest;
        tag_t     tag;
        data_t    data;
    } writeback_t;

    // Dispatch tag update into the register map
    typedef struct packed {
        logic     wr_en;
        reg_idx_t rdest;
        tag_t     tag;
    } tag_write_t;

endpackage
